/* conv_layer_3x3.f */
+incdir+include
verilog/conv_layer_pkg.sv
verilog/conv_loop_buffer.sv
verilog/conv_window_3x3.sv
verilog/conv_weight_buffer.sv
verilog/conv_mac_3x3.sv
verilog/conv_channel_adder.sv
verilog/conv_layer_3x3.sv
verification/conv_layer_3x3_tb.sv

/* Bender.yml */
package:
  name: conv_layer_3x3

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/conv_layer_pkg.sv
      - verilog/conv_loop_buffer.sv
      - verilog/conv_window_3x3.sv
      - verilog/conv_weight_buffer.sv
      - verilog/conv_mac_3x3.sv
      - verilog/conv_channel_adder.sv
      - verilog/conv_layer_3x3.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/conv_layer_3x3_tb.sv

/* verification/conv_layer_3x3_tb.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_layer_3x3_tb;

  import conv_layer_pkg::*;

  localparam int IMG_W       = `CONV_IMG_W;
  localparam int IMG_H       = `CONV_IMG_H;
  localparam int IMG_SIZE    = IMG_W * IMG_H;
  localparam int IMG_DEPTH   = IMG_SIZE * `CONV_CH_IN;
  localparam int W_COUNT     = `CONV_CH_OUT * `CONV_CH_IN * 9;
  localparam int MAX_IDLE    = 3;
  localparam int NUM_CASES   = 7;
  // Worst case per case covers the weight load, a gapped fill and every replayed plane
  localparam int PLANE_BOUND = IMG_SIZE + `CONV_PLANE_GAP + 4;
  localparam int CASE_BOUND  = W_COUNT + IMG_DEPTH * (MAX_IDLE + 1)
                               + `CONV_CH_OUT * `CONV_CH_IN * PLANE_BOUND;
  localparam int CYCLE_LIMIT = 10 + NUM_CASES * CASE_BOUND + 200;

  typedef enum logic [1:0] {PIX_SMALL, PIX_CONST, PIX_MAX, PIX_FULL} pix_kind_e;
  typedef enum logic [1:0] {W_IDENTITY, W_ONES, W_NEG_ONES, W_RANDOM} wt_kind_e;

  typedef struct packed {
    pix_kind_e  pix_kind;
    wt_kind_e   wt_kind;
    logic [6:0] gap_pct;
  } case_t;

  ////////////////////////////////////////////////////////////
  // Cases run back to back without a reset between them
  case_t case_table [NUM_CASES] = '{
    '{PIX_SMALL, W_IDENTITY, 7'd0},
    '{PIX_CONST, W_ONES,     7'd0},
    '{PIX_SMALL, W_RANDOM,   7'd0},
    '{PIX_MAX,   W_ONES,     7'd0},
    '{PIX_MAX,   W_NEG_ONES, 7'd30},
    '{PIX_SMALL, W_RANDOM,   7'd50},
    '{PIX_FULL,  W_RANDOM,   7'd20}
  };

  logic   clk;
  logic   reset;
  logic   valid_in;
  pixel_t pxl_in;
  logic   valid_weight_in;
  pixel_t weight_in;
  logic   valid_out;
  pixel_t pxl_out;

  // Current image (channel major) and weights (out, in, tap)
  int img [IMG_DEPTH];
  int wts [W_COUNT];
  int exp_q [$];
  int cycle_count = 0;

  conv_layer_3x3 uut (
    .clk            (clk),
    .reset          (reset),
    .valid_in       (valid_in),
    .pxl_in         (pxl_in),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .valid_out      (valid_out),
    .pxl_out        (pxl_out)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model does padded correlation then shift and clamp
  function automatic int model_pixel(int o, int p);
    longint acc;
    int row;
    int col;
    int y;
    int x;
    acc = 0;
    row = p / IMG_W;
    col = p % IMG_W;
    for (int i = 0; i < `CONV_CH_IN; i++) begin
      for (int dr = 0; dr < 3; dr++) begin
        for (int dc = 0; dc < 3; dc++) begin
          y = row + dr - 1;
          x = col + dc - 1;
          if (y >= 0 && y < IMG_H && x >= 0 && x < IMG_W) begin
            acc = acc + longint'(img[i * IMG_SIZE + y * IMG_W + x])
                      * longint'(wts[(o * `CONV_CH_IN + i) * 9 + dr * 3 + dc]);
          end
        end
      end
    end
    acc = acc >>> `CONV_OUT_SHIFT;
    if (acc > 32767) acc = 32767;
    if (acc < -32768) acc = -32768;
    return int'(acc);
  endfunction

  function automatic int gen_pixel(pix_kind_e kind);
    case (kind)
      PIX_SMALL: return int'($urandom_range(510)) - 255;
      PIX_CONST: return 100;
      PIX_MAX:   return 32767;
      default:   return int'(pixel_t'($urandom()));
    endcase
  endfunction

  function automatic int gen_weight(wt_kind_e kind, int tap);
    case (kind)
      W_IDENTITY: return (tap == 4) ? 16 : 0;
      W_ONES:     return 1;
      W_NEG_ONES: return -1;
      default:    return int'($urandom_range(254)) - 127;
    endcase
  endfunction

  task automatic load_weights();
    for (int k = 0; k < W_COUNT; k++) begin
      @(posedge clk);
      valid_weight_in <= 1'b1;
      weight_in       <= pixel_t'(wts[k]);
    end
    @(posedge clk);
    valid_weight_in <= 1'b0;
  endtask

  // Up to MAX_IDLE random idle cycles before a pixel
  task automatic load_image(int gap_pct);
    int idle;
    for (int k = 0; k < IMG_DEPTH; k++) begin
      if (int'($urandom_range(99)) < gap_pct) begin
        idle = int'($urandom_range(MAX_IDLE, 1));
        repeat (idle) begin
          @(posedge clk);
          valid_in <= 1'b0;
        end
      end
      @(posedge clk);
      valid_in <= 1'b1;
      pxl_in   <= pixel_t'(img[k]);
    end
    @(posedge clk);
    valid_in <= 1'b0;
  endtask

  task automatic run_case(int n, case_t tc);
    for (int k = 0; k < W_COUNT; k++) begin
      wts[k] = gen_weight(tc.wt_kind, k % 9);
    end
    for (int k = 0; k < IMG_DEPTH; k++) begin
      img[k] = gen_pixel(tc.pix_kind);
    end
    $display("Case %0d: pixels %s, weights %s, gaps %0d%%", n, tc.pix_kind.name(),
             tc.wt_kind.name(), tc.gap_pct);
    load_weights();
    // Output channel major, then raster order
    for (int o = 0; o < `CONV_CH_OUT; o++) begin
      for (int p = 0; p < IMG_SIZE; p++) begin
        exp_q.push_back(model_pixel(o, p));
      end
    end
    load_image(tc.gap_pct);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor flags any result with nothing pending
  always @(negedge clk) begin
    if (!reset && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("valid_out asserted at %0t with no result pending", $time);
        $display("CHECKS FAILED");
        $fatal(1, "Unexpected output");
      end else begin
        check_value("pxl_out", exp_q.pop_front(), pxl_out);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, results still missing", cycle_count);
      $display("CHECKS FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    void'($urandom(32'h77ba));
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int n = 0; n < NUM_CASES; n++) begin
      run_case(n, case_table[n]);
    end
    // Idle tail lets the monitor catch stray results
    repeat (4 * `CONV_PLANE_GAP) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog/conv_layer_3x3.sv */
`timescale 1ns/100ps

module conv_layer_3x3 (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   valid_in,
  input  conv_layer_pkg::pixel_t pxl_in,
  input  logic                   valid_weight_in,
  input  conv_layer_pkg::pixel_t weight_in,
  output logic                   valid_out,
  output conv_layer_pkg::pixel_t pxl_out
);

  import conv_layer_pkg::*;

  // Replayed planes
  logic       loop_valid;
  pixel_t     loop_pxl;
  plane_tag_t loop_tag;

  // Padded windows
  logic       win_valid;
  window_t    win_data;
  plane_tag_t win_tag;
  kernel_t    kernel;

  // Per-channel convolution results
  logic       mac_valid;
  acc_t       mac_sum;
  plane_tag_t mac_tag;

  conv_loop_buffer u_loop (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .loop_valid(loop_valid),
    .loop_pxl  (loop_pxl),
    .loop_tag  (loop_tag)
  );

  conv_window_3x3 u_window (
    .clk       (clk),
    .reset     (reset),
    .loop_valid(loop_valid),
    .loop_pxl  (loop_pxl),
    .loop_tag  (loop_tag),
    .win_valid (win_valid),
    .win_data  (win_data),
    .win_tag   (win_tag)
  );

  conv_weight_buffer u_weights (
    .clk            (clk),
    .reset          (reset),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .win_tag        (win_tag),
    .kernel         (kernel)
  );

  conv_mac_3x3 u_mac (
    .clk      (clk),
    .reset    (reset),
    .win_valid(win_valid),
    .win_data (win_data),
    .kernel   (kernel),
    .win_tag  (win_tag),
    .mac_valid(mac_valid),
    .mac_sum  (mac_sum),
    .mac_tag  (mac_tag)
  );

  conv_channel_adder u_adder (
    .clk      (clk),
    .reset    (reset),
    .mac_valid(mac_valid),
    .mac_sum  (mac_sum),
    .mac_tag  (mac_tag),
    .valid_out(valid_out),
    .pxl_out  (pxl_out)
  );

endmodule

/* verilog/conv_channel_adder.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_channel_adder (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       mac_valid,
  input  conv_layer_pkg::acc_t       mac_sum,
  input  conv_layer_pkg::plane_tag_t mac_tag,
  output logic                       valid_out,
  output conv_layer_pkg::pixel_t     pxl_out
);

  import conv_layer_pkg::*;

  // Signed pixel range
  localparam acc_t PXL_MAX = acc_t'((1 << (`CONV_DATA_W - 1)) - 1);
  localparam acc_t PXL_MIN = -PXL_MAX - 1;

  acc_t psum_mem [`CONV_IMG_SIZE];
  acc_t psum_prev;
  acc_t total;
  acc_t shifted;

  function automatic pixel_t saturate(acc_t value);
    pixel_t result;
    if (value > PXL_MAX) begin
      result = pixel_t'(PXL_MAX);
    end else if (value < PXL_MIN) begin
      result = pixel_t'(PXL_MIN);
    end else begin
      result = pixel_t'(value);
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Input channel 0 starts a fresh sum
  assign psum_prev = (mac_tag.ch_in == 2'd0) ? acc_t'(0) : psum_mem[mac_tag.pxl_idx];
  assign total     = psum_prev + mac_sum;
  assign shifted   = total >>> `CONV_OUT_SHIFT;

  // Partial sums only, the final channel goes straight out
  always_ff @(posedge clk) begin
    if (mac_valid && !mac_tag.last_ch_in) begin
      psum_mem[mac_tag.pxl_idx] <= total;
    end
  end

  always_ff @(posedge clk) begin
    if (mac_valid && mac_tag.last_ch_in) begin
      pxl_out <= saturate(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= mac_valid && mac_tag.last_ch_in;
    end
  end

endmodule

/* verilog/conv_mac_3x3.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_mac_3x3 (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       win_valid,
  input  conv_layer_pkg::window_t    win_data,
  input  conv_layer_pkg::kernel_t    kernel,
  input  conv_layer_pkg::plane_tag_t win_tag,
  output logic                       mac_valid,
  output conv_layer_pkg::acc_t       mac_sum,
  output conv_layer_pkg::plane_tag_t mac_tag
);

  import conv_layer_pkg::*;

  acc_t       prod [`CONV_TAPS];
  logic       prod_valid;
  plane_tag_t prod_tag;
  acc_t       sum_nxt;

  ////////////////////////////////////////////////////////////
  // Stage one, nine signed products
  always_ff @(posedge clk) begin
    for (int i = 0; i < `CONV_TAPS; i++) begin
      prod[i] <= acc_t'(win_data.tap[i]) * acc_t'(kernel.tap[i]);
    end
    prod_tag <= win_tag;
  end

  // Adder tree
  always_comb begin
    sum_nxt = '0;
    for (int i = 0; i < `CONV_TAPS; i++) begin
      sum_nxt = sum_nxt + prod[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage two, registered sum
  always_ff @(posedge clk) begin
    mac_sum <= sum_nxt;
    mac_tag <= prod_tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      mac_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      mac_valid  <= prod_valid;
    end
  end

endmodule

/* verilog/conv_weight_buffer.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_weight_buffer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       valid_weight_in,
  input  conv_layer_pkg::pixel_t     weight_in,
  input  conv_layer_pkg::plane_tag_t win_tag,
  output conv_layer_pkg::kernel_t    kernel
);

  import conv_layer_pkg::*;

  localparam int DEPTH  = `CONV_CH_OUT * `CONV_CH_IN * `CONV_TAPS;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t            w_mem [DEPTH];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] base_addr;

  ////////////////////////////////////////////////////////////
  // Load order is output channel, input channel, tap
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
    end else if (valid_weight_in) begin
      if (wr_addr == ADDR_W'(DEPTH - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      w_mem[wr_addr] <= weight_in;
    end
  end

  // First tap of the kernel for this channel pair
  assign base_addr = ADDR_W'((win_tag.ch_out * `CONV_CH_IN + win_tag.ch_in) * `CONV_TAPS);

  always_comb begin
    for (int i = 0; i < `CONV_TAPS; i++) begin
      kernel.tap[i] = w_mem[base_addr + ADDR_W'(i)];
    end
  end

endmodule

/* verilog/conv_window_3x3.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_window_3x3 (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       loop_valid,
  input  conv_layer_pkg::pixel_t     loop_pxl,
  input  conv_layer_pkg::plane_tag_t loop_tag,
  output logic                       win_valid,
  output conv_layer_pkg::window_t    win_data,
  output conv_layer_pkg::plane_tag_t win_tag
);

  import conv_layer_pkg::*;

  localparam int IMG_W  = `CONV_IMG_W;
  localparam int IMG_H  = `CONV_IMG_H;
  // Newest pixel runs this far ahead of the window centre
  localparam int LAG    = IMG_W + 1;
  localparam int HEAD_W = $clog2(`CONV_IMG_SIZE + LAG + 1);
  localparam int LB_LEN = IMG_W - 3;
  localparam int ROW_W  = $clog2(IMG_H);
  localparam int COL_W  = $clog2(IMG_W);

  pixel_t            win_reg [3][3];
  pixel_t            lb [2][LB_LEN];
  logic [HEAD_W-1:0] head;
  logic [HEAD_W-1:0] cur_pos;
  logic              flush;
  logic              shift;
  logic              emit;
  pixel_t            shift_in;
  plane_tag_t        plane_tag;
  plane_tag_t        tag_src;
  logic [ROW_W-1:0]  nxt_row;
  logic [COL_W-1:0]  nxt_col;
  logic [ROW_W-1:0]  ctr_row;
  logic [COL_W-1:0]  ctr_col;
  logic [2:0]        row_ok;
  logic [2:0]        col_ok;

  ////////////////////////////////////////////////////////////
  // Stream position and flush control
  assign cur_pos  = loop_valid ? HEAD_W'(loop_tag.pxl_idx) : head;
  // Keep shifting after the last pixel until the final centre is out
  assign flush    = !loop_valid && (head >= HEAD_W'(`CONV_IMG_SIZE))
                    && (head < HEAD_W'(`CONV_IMG_SIZE + LAG));
  assign shift    = loop_valid || flush;
  assign emit     = shift && (cur_pos >= HEAD_W'(LAG));
  assign shift_in = loop_valid ? loop_pxl : '0;
  assign tag_src  = loop_valid ? loop_tag : plane_tag;

  always_ff @(posedge clk) begin
    if (reset) begin
      head <= '0;
    end else if (shift) begin
      head <= cur_pos + 1'b1;
    end
  end

  // Two line buffers between the three window rows
  always_ff @(posedge clk) begin
    if (shift) begin
      for (int r = 0; r < 3; r++) begin
        win_reg[r][0] <= win_reg[r][1];
        win_reg[r][1] <= win_reg[r][2];
      end
      win_reg[2][2] <= shift_in;
      win_reg[1][2] <= lb[1][LB_LEN-1];
      win_reg[0][2] <= lb[0][LB_LEN-1];
      lb[1][0]      <= win_reg[2][0];
      lb[0][0]      <= win_reg[1][0];
      for (int i = 1; i < LB_LEN; i++) begin
        lb[1][i] <= lb[1][i-1];
        lb[0][i] <= lb[0][i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Centre position of the window leaving next
  always_ff @(posedge clk) begin
    if (reset) begin
      nxt_row <= '0;
      nxt_col <= '0;
      ctr_row <= '0;
      ctr_col <= '0;
    end else if (loop_valid && loop_tag.pxl_idx == '0) begin
      nxt_row <= '0;
      nxt_col <= '0;
    end else if (emit) begin
      ctr_row <= nxt_row;
      ctr_col <= nxt_col;
      if (nxt_col == COL_W'(IMG_W - 1)) begin
        nxt_col <= '0;
        nxt_row <= nxt_row + 1'b1;
      end else begin
        nxt_col <= nxt_col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loop_valid) begin
      plane_tag <= loop_tag;
    end
    if (emit) begin
      win_tag <= '{ch_in: tag_src.ch_in, ch_out: tag_src.ch_out,
                   pxl_idx: 6'(cur_pos - HEAD_W'(LAG)), last_ch_in: tag_src.last_ch_in};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= emit;
    end
  end

  // Zero padding around the image border
  assign row_ok = {ctr_row != ROW_W'(IMG_H - 1), 1'b1, ctr_row != '0};
  assign col_ok = {ctr_col != COL_W'(IMG_W - 1), 1'b1, ctr_col != '0};

  always_comb begin
    win_data = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        if (row_ok[r] && col_ok[c]) begin
          win_data.tap[3*r+c] = win_reg[r][c];
        end
      end
    end
  end

endmodule

/* verilog/conv_loop_buffer.sv */
`timescale 1ns/100ps
`include "conv_layer_settings.svh"

module conv_loop_buffer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       valid_in,
  input  conv_layer_pkg::pixel_t     pxl_in,
  output logic                       loop_valid,
  output conv_layer_pkg::pixel_t     loop_pxl,
  output conv_layer_pkg::plane_tag_t loop_tag
);

  import conv_layer_pkg::*;

  localparam int IMG_DEPTH = `CONV_IMG_SIZE * `CONV_CH_IN;
  localparam int ADDR_W    = $clog2(IMG_DEPTH);
  localparam int GAP_W     = $clog2(`CONV_PLANE_GAP + 1);

  loop_state_e       state;
  pixel_t            img_mem [IMG_DEPTH];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [5:0]        pxl_cnt;
  logic [1:0]        ch_in_cnt;
  logic [1:0]        ch_out_cnt;
  logic [GAP_W-1:0]  gap_cnt;
  logic              final_plane;
  logic              plane_end;
  logic              ch_in_last;
  logic              ch_out_last;

  assign plane_end   = (pxl_cnt == 6'(`CONV_IMG_SIZE - 1));
  assign ch_in_last  = (ch_in_cnt == 2'(`CONV_CH_IN - 1));
  assign ch_out_last = (ch_out_cnt == 2'(`CONV_CH_OUT - 1));

  // Image store, written only while filling
  always_ff @(posedge clk) begin
    if (state == LOOP_FILL && valid_in) begin
      img_mem[wr_addr] <= pxl_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Fill, then replay every input plane once per output channel
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= LOOP_FILL;
      wr_addr     <= '0;
      rd_addr     <= '0;
      pxl_cnt     <= '0;
      ch_in_cnt   <= '0;
      ch_out_cnt  <= '0;
      gap_cnt     <= '0;
      final_plane <= 1'b0;
    end else begin
      case (state)
        LOOP_FILL: begin
          if (valid_in) begin
            if (wr_addr == ADDR_W'(IMG_DEPTH - 1)) begin
              wr_addr <= '0;
              state   <= LOOP_REPLAY;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end
        LOOP_REPLAY: begin
          pxl_cnt <= pxl_cnt + 1'b1;
          rd_addr <= rd_addr + 1'b1;
          if (plane_end) begin
            pxl_cnt <= '0;
            gap_cnt <= '0;
            state   <= LOOP_GAP;
            if (ch_in_last) begin
              // Next output channel restarts at input plane 0
              ch_in_cnt <= '0;
              rd_addr   <= '0;
              if (ch_out_last) begin
                ch_out_cnt  <= '0;
                final_plane <= 1'b1;
              end else begin
                ch_out_cnt <= ch_out_cnt + 1'b1;
              end
            end else begin
              ch_in_cnt <= ch_in_cnt + 1'b1;
            end
          end
        end
        LOOP_GAP: begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_W'(`CONV_PLANE_GAP - 1)) begin
            state       <= final_plane ? LOOP_FILL : LOOP_REPLAY;
            final_plane <= 1'b0;
          end
        end
        default: state <= LOOP_FILL;
      endcase
    end
  end

  // Registered read port with its tag
  always_ff @(posedge clk) begin
    loop_pxl <= img_mem[rd_addr];
    loop_tag <= '{ch_in: ch_in_cnt, ch_out: ch_out_cnt, pxl_idx: pxl_cnt,
                  last_ch_in: ch_in_last};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      loop_valid <= 1'b0;
    end else begin
      loop_valid <= (state == LOOP_REPLAY);
    end
  end

endmodule

/* verilog/conv_layer_pkg.sv */
`include "conv_layer_settings.svh"

package conv_layer_pkg;

  ////////////////////////////////////////////////////////////
  // Scalar data words
  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
  typedef logic signed [`CONV_ACC_W-1:0]  acc_t;

  ////////////////////////////////////////////////////////////
  // 3x3 neighbourhood, tap 0 is top-left, row-major
  typedef struct packed {
    pixel_t [`CONV_TAPS-1:0] tap;
  } window_t;

  // Kernel weights in the same tap order as window_t
  typedef struct packed {
    pixel_t [`CONV_TAPS-1:0] tap;
  } kernel_t;

  ////////////////////////////////////////////////////////////
  // Travels with every pixel from the loop buffer to the adder
  typedef struct packed {
    logic [1:0] ch_in;
    logic [1:0] ch_out;
    logic [5:0] pxl_idx;
    // Set on the final input channel of an output plane
    logic       last_ch_in;
  } plane_tag_t;

  // Loop buffer sequencer
  typedef enum logic [1:0] {
    LOOP_FILL   = 2'd0,
    LOOP_REPLAY = 2'd1,
    LOOP_GAP    = 2'd2
  } loop_state_e;

endpackage

/* include/conv_layer_settings.svh */
`ifndef CONV_LAYER_SETTINGS_SVH
`define CONV_LAYER_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Image geometry
`define CONV_IMG_W      6
`define CONV_IMG_H      6
`define CONV_IMG_SIZE   (`CONV_IMG_W * `CONV_IMG_H)

// Channel counts
`define CONV_CH_IN      2
`define CONV_CH_OUT     3

////////////////////////////////////////////////////////////
// Data widths, all signed
`define CONV_DATA_W     16
`define CONV_ACC_W      40
`define CONV_TAPS       9

// Requantization before the clamp to the pixel range
`define CONV_OUT_SHIFT  4

// Idle cycles after each replayed plane, long enough to flush a row
`define CONV_PLANE_GAP  (`CONV_IMG_W + 2)

`endif
